/* cbp_consts.svh */
`ifndef CBP_CONSTS_SVH
`define CBP_CONSTS_SVH

// ********************************************************************
// predictor sizes
// ********************************************************************

// program counter width
`define CBP_PC_WIDTH 32

// global history length, also the width of every table index
`define CBP_HIST_WIDTH 8

// entries per counter table, 2**CBP_HIST_WIDTH
`define CBP_TABLE_DEPTH 256

// instructions are word aligned so the two low pc bits carry nothing
`define CBP_IDX_LSB 2

// ********************************************************************
// counter encoding
// ********************************************************************

// weakly not-taken, prefer local
`define CBP_CTR_RESET 1

`endif

/* cbp_pkg.sv */
`default_nettype none

`include "cbp_consts.svh"

package cbp_pkg;

	// ********************************************************************
	// shared predictor types
	// ********************************************************************

	// fetch or commit address
	typedef logic [`CBP_PC_WIDTH-1:0] pc_t;

	// speculative global history
	// newest outcome sits in bit 0
	typedef logic [`CBP_HIST_WIDTH-1:0] hist_t;

	// index into the local, global and chooser tables
	typedef logic [`CBP_HIST_WIDTH-1:0] idx_t;

	// two-bit saturating counter
	// 2 and 3 mean taken, for the chooser prefer global
	// 0 and 1 mean not-taken, for the chooser prefer local
	typedef logic [1:0] ctr_t;

endpackage

`default_nettype wire

/* sat_counter_table.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cbp_consts.svh"

module sat_counter_table (
	input  wire logic          clk_i,
	input  wire logic          rst_i,
	// lookup side
	input  cbp_pkg::idx_t      rd_idx_i,
	output cbp_pkg::ctr_t      rd_ctr_o,
	// training side
	input  wire logic          wr_en_i,
	input  cbp_pkg::idx_t      wr_idx_i,
	input  wire logic          wr_up_i
);

	// counter storage
	cbp_pkg::ctr_t table_q [`CBP_TABLE_DEPTH];

	cbp_pkg::ctr_t wr_cur_ctr;
	cbp_pkg::ctr_t wr_nxt_ctr;

	// ********************************************************************
	// read port
	// ********************************************************************

	// combinational read, a write in this cycle is not seen yet
	assign rd_ctr_o = table_q[rd_idx_i];

	// ********************************************************************
	// update port
	// ********************************************************************

	assign wr_cur_ctr = table_q[wr_idx_i];

	// one step toward taken or not-taken, saturating at 0 and 3
	always_comb begin
		wr_nxt_ctr = wr_cur_ctr;
		if (wr_up_i) begin
			if (wr_cur_ctr != 2'd3) begin
				wr_nxt_ctr = wr_cur_ctr + 2'd1;
			end
		end else begin
			if (wr_cur_ctr != 2'd0) begin
				wr_nxt_ctr = wr_cur_ctr - 2'd1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			// every entry back to weakly not-taken
			for (int i = 0; i < `CBP_TABLE_DEPTH; i++) begin
				table_q[i] <= cbp_pkg::ctr_t'(`CBP_CTR_RESET);
			end
		end else if (wr_en_i) begin
			table_q[wr_idx_i] <= wr_nxt_ctr;
		end
	end

endmodule

`default_nettype wire

/* global_history.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cbp_consts.svh"

module global_history (
	input  wire logic          clk_i,
	input  wire logic          rst_i,
	// fetch side
	input  wire logic          lookup_valid_i,
	input  wire logic          predict_taken_i,
	// execute side
	input  wire logic          resolve_valid_i,
	input  cbp_pkg::hist_t     resolve_history_i,
	input  wire logic          resolve_predict_i,
	input  wire logic          resolve_taken_i,
	// current speculative history
	output cbp_pkg::hist_t     history_o
);

	cbp_pkg::hist_t history_q;
	cbp_pkg::hist_t history_d;

	logic mispredict;

	// a correct resolve leaves the history alone
	assign mispredict = resolve_valid_i & (resolve_predict_i != resolve_taken_i);

	// ********************************************************************
	// next history
	// ********************************************************************

	always_comb begin
		history_d = history_q;
		if (mispredict) begin
			// rebuild from the history the branch saw plus its real outcome
			history_d = {resolve_history_i[`CBP_HIST_WIDTH-2:0], resolve_taken_i};
		end else if (lookup_valid_i) begin
			// speculative shift with the chosen prediction
			history_d = {history_q[`CBP_HIST_WIDTH-2:0], predict_taken_i};
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			history_q <= '0;
		end else begin
			history_q <= history_d;
		end
	end

	assign history_o = history_q;

endmodule

`default_nettype wire

/* predict_select.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cbp_consts.svh"

module predict_select (
	// lookup address and current history
	input  cbp_pkg::pc_t       lookup_pc_i,
	input  cbp_pkg::hist_t     history_i,
	// counters read from the three tables
	input  cbp_pkg::ctr_t      local_ctr_i,
	input  cbp_pkg::ctr_t      global_ctr_i,
	input  cbp_pkg::ctr_t      chooser_ctr_i,
	// read indices, the chooser shares the local one
	output cbp_pkg::idx_t      local_idx_o,
	output cbp_pkg::idx_t      global_idx_o,
	// component and final predictions
	output logic               local_predict_o,
	output logic               global_predict_o,
	output logic               predict_taken_o
);

	cbp_pkg::idx_t pc_idx;
	logic          prefer_global;

	// ********************************************************************
	// lookup indices
	// ********************************************************************

	// word address bits of the fetch pc
	assign pc_idx = lookup_pc_i[`CBP_IDX_LSB +: `CBP_HIST_WIDTH];

	assign local_idx_o  = pc_idx;

	// gshare style hash
	assign global_idx_o = pc_idx ^ history_i;

	// ********************************************************************
	// direction and choice
	// ********************************************************************

	// upper counter bit gives the direction
	assign local_predict_o  = local_ctr_i[1];
	assign global_predict_o = global_ctr_i[1];

	// chooser in the upper half trusts global
	assign prefer_global = chooser_ctr_i[1];

	always_comb begin
		if (prefer_global) begin
			predict_taken_o = global_predict_o;
		end else begin
			predict_taken_o = local_predict_o;
		end
	end

endmodule

`default_nettype wire

/* predictor_update.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cbp_consts.svh"

module predictor_update (
	// committed branch
	input  wire logic          train_valid_i,
	input  cbp_pkg::pc_t       train_pc_i,
	input  cbp_pkg::hist_t     train_history_i,
	input  wire logic          train_taken_i,
	// component predictions seen at lookup
	input  wire logic          train_local_predict_i,
	input  wire logic          train_global_predict_i,
	// write indices
	output cbp_pkg::idx_t      local_idx_o,
	output cbp_pkg::idx_t      global_idx_o,
	// write enables and chooser direction
	output logic               counter_en_o,
	output logic               chooser_en_o,
	output logic               chooser_up_o
);

	cbp_pkg::idx_t pc_idx;
	logic          components_differ;
	logic          global_correct;

	// ********************************************************************
	// training indices
	// ********************************************************************

	// same hash as at lookup, with the history the branch used then
	assign pc_idx = train_pc_i[`CBP_IDX_LSB +: `CBP_HIST_WIDTH];

	assign local_idx_o  = pc_idx;
	assign global_idx_o = pc_idx ^ train_history_i;

	// ********************************************************************
	// write control
	// ********************************************************************

	// local and global learn from every committed branch
	assign counter_en_o = train_valid_i;

	// chooser only learns when the two components disagree
	assign components_differ = train_local_predict_i ^ train_global_predict_i;

	assign global_correct = (train_global_predict_i == train_taken_i);

	always_comb begin
		chooser_en_o = 1'b0;
		if (train_valid_i && components_differ) begin
			chooser_en_o = 1'b1;
		end
	end

	// up means trust global more
	assign chooser_up_o = global_correct;

endmodule

`default_nettype wire

/* branch_predictor.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cbp_consts.svh"

module branch_predictor (
	input  wire logic          clk_i,
	input  wire logic          rst_i,
	// lookup, from fetch
	input  wire logic          lookup_valid_i,
	input  cbp_pkg::pc_t       lookup_pc_i,
	// resolve, from execute
	input  wire logic          resolve_valid_i,
	input  cbp_pkg::hist_t     resolve_history_i,
	input  wire logic          resolve_predict_i,
	input  wire logic          resolve_taken_i,
	// train, from commit
	input  wire logic          train_valid_i,
	input  cbp_pkg::pc_t       train_pc_i,
	input  cbp_pkg::hist_t     train_history_i,
	input  wire logic          train_taken_i,
	input  wire logic          train_local_predict_i,
	input  wire logic          train_global_predict_i,
	// lookup results, same cycle
	output logic               predict_taken_o,
	output logic               local_predict_o,
	output logic               global_predict_o,
	output cbp_pkg::hist_t     lookup_history_o
);

	// ********************************************************************
	// internal wires
	// ********************************************************************

	// history
	cbp_pkg::hist_t history;

	// lookup path
	cbp_pkg::idx_t  rd_local_idx;
	cbp_pkg::idx_t  rd_global_idx;
	cbp_pkg::ctr_t  local_ctr;
	cbp_pkg::ctr_t  global_ctr;
	cbp_pkg::ctr_t  chooser_ctr;
	logic           predict_taken;

	// training path
	cbp_pkg::idx_t  wr_local_idx;
	cbp_pkg::idx_t  wr_global_idx;
	logic           counter_en;
	logic           chooser_en;
	logic           chooser_up;

	// ********************************************************************
	// speculative history
	// ********************************************************************

	global_history global_history_i (
		.clk_i              (clk_i),
		.rst_i              (rst_i),
		.lookup_valid_i     (lookup_valid_i),
		.predict_taken_i    (predict_taken),
		.resolve_valid_i    (resolve_valid_i),
		.resolve_history_i  (resolve_history_i),
		.resolve_predict_i  (resolve_predict_i),
		.resolve_taken_i    (resolve_taken_i),
		.history_o          (history)
	);

	// ********************************************************************
	// lookup
	// ********************************************************************

	predict_select predict_select_i (
		.lookup_pc_i        (lookup_pc_i),
		.history_i          (history),
		.local_ctr_i        (local_ctr),
		.global_ctr_i       (global_ctr),
		.chooser_ctr_i      (chooser_ctr),
		.local_idx_o        (rd_local_idx),
		.global_idx_o       (rd_global_idx),
		.local_predict_o    (local_predict_o),
		.global_predict_o   (global_predict_o),
		.predict_taken_o    (predict_taken)
	);

	assign predict_taken_o  = predict_taken;
	assign lookup_history_o = history;

	// ********************************************************************
	// training
	// ********************************************************************

	predictor_update predictor_update_i (
		.train_valid_i          (train_valid_i),
		.train_pc_i             (train_pc_i),
		.train_history_i        (train_history_i),
		.train_taken_i          (train_taken_i),
		.train_local_predict_i  (train_local_predict_i),
		.train_global_predict_i (train_global_predict_i),
		.local_idx_o            (wr_local_idx),
		.global_idx_o           (wr_global_idx),
		.counter_en_o           (counter_en),
		.chooser_en_o           (chooser_en),
		.chooser_up_o           (chooser_up)
	);

	// ********************************************************************
	// counter tables
	// ********************************************************************

	// per pc
	sat_counter_table local_table (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.rd_idx_i   (rd_local_idx),
		.rd_ctr_o   (local_ctr),
		.wr_en_i    (counter_en),
		.wr_idx_i   (wr_local_idx),
		.wr_up_i    (train_taken_i)
	);

	// pc hashed with history
	sat_counter_table global_table (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.rd_idx_i   (rd_global_idx),
		.rd_ctr_o   (global_ctr),
		.wr_en_i    (counter_en),
		.wr_idx_i   (wr_global_idx),
		.wr_up_i    (train_taken_i)
	);

	// chooser shares the local index
	sat_counter_table chooser_table (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.rd_idx_i   (rd_local_idx),
		.rd_ctr_o   (chooser_ctr),
		.wr_en_i    (chooser_en),
		.wr_idx_i   (wr_local_idx),
		.wr_up_i    (chooser_up)
	);

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic clk_o
);

	// 4 ns period
	localparam real HALF_PERIOD = 2.0;

	initial begin
		clk_o = 1'b0;
	end

	always begin
		#(HALF_PERIOD);
		clk_o = ~clk_o;
	end

endmodule

`default_nettype wire

/* tb_branch_predictor.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cbp_consts.svh"

module tb_branch_predictor;

	localparam int NUM_ROWS       = 29;
	localparam int RESET_CYCLES   = 16;
	localparam int TIMEOUT_CYCLES = 4 * NUM_ROWS + RESET_CYCLES;

	// operation codes of a table row
	localparam int OP_IDLE           = 0;
	localparam int OP_LOOKUP         = 1;
	localparam int OP_RESOLVE        = 2;
	localparam int OP_TRAIN          = 3;
	localparam int OP_RESOLVE_LOOKUP = 4;

	// pc word index 0x40, 0x80, 0xc0 and 0x00
	localparam cbp_pkg::pc_t PC_A = 32'h0000_0100;
	localparam cbp_pkg::pc_t PC_B = 32'h0000_0200;
	localparam cbp_pkg::pc_t PC_C = 32'h0000_0300;
	localparam cbp_pkg::pc_t PC_D = 32'h0000_0400;

	logic           clk_i;
	logic           rst_i;
	logic           lookup_valid_i;
	cbp_pkg::pc_t   lookup_pc_i;
	logic           resolve_valid_i;
	cbp_pkg::hist_t resolve_history_i;
	logic           resolve_predict_i;
	logic           resolve_taken_i;
	logic           train_valid_i;
	cbp_pkg::pc_t   train_pc_i;
	cbp_pkg::hist_t train_history_i;
	logic           train_taken_i;
	logic           train_local_predict_i;
	logic           train_global_predict_i;
	logic           predict_taken_o;
	logic           local_predict_o;
	logic           global_predict_o;
	cbp_pkg::hist_t lookup_history_o;

	// stimulus and expected values per cycle
	int             row_op [NUM_ROWS];
	cbp_pkg::pc_t   row_pc [NUM_ROWS];
	cbp_pkg::hist_t row_hist [NUM_ROWS];
	logic           row_predict [NUM_ROWS];
	logic           row_taken [NUM_ROWS];
	logic           row_local [NUM_ROWS];
	logic           row_global [NUM_ROWS];
	logic [2:0]     row_exp_plg [NUM_ROWS];
	cbp_pkg::hist_t row_exp_hist [NUM_ROWS];

	int num_rows    = 0;
	int cur_row     = 0;
	int cycle_count = 0;

	tb_clock_gen clock_gen_i (
		.clk_o (clk_i)
	);

	branch_predictor branch_predictor_i (
		.clk_i                  (clk_i),
		.rst_i                  (rst_i),
		.lookup_valid_i         (lookup_valid_i),
		.lookup_pc_i            (lookup_pc_i),
		.resolve_valid_i        (resolve_valid_i),
		.resolve_history_i      (resolve_history_i),
		.resolve_predict_i      (resolve_predict_i),
		.resolve_taken_i        (resolve_taken_i),
		.train_valid_i          (train_valid_i),
		.train_pc_i             (train_pc_i),
		.train_history_i        (train_history_i),
		.train_taken_i          (train_taken_i),
		.train_local_predict_i  (train_local_predict_i),
		.train_global_predict_i (train_global_predict_i),
		.predict_taken_o        (predict_taken_o),
		.local_predict_o        (local_predict_o),
		.global_predict_o       (global_predict_o),
		.lookup_history_o       (lookup_history_o)
	);

	// ********************************************************************
	// compare tasks
	// ********************************************************************

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("FAILED %s row %0d: expected 0x%0h, got 0x%0h",
				name, cur_row, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_hist(input string name, input cbp_pkg::hist_t actual,
			input cbp_pkg::hist_t expected);
		if (actual !== expected) begin
			$display("FAILED %s row %0d: expected 0x%02h, got 0x%02h",
				name, cur_row, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// ********************************************************************
	// table handling
	// ********************************************************************

	task automatic add_row(input int op, input cbp_pkg::pc_t pc, input cbp_pkg::hist_t hist,
			input logic rp, input logic taken, input logic tl, input logic tg,
			input logic [2:0] exp_plg, input cbp_pkg::hist_t exp_hist);
		if (num_rows < NUM_ROWS) begin
			row_op[num_rows]       = op;
			row_pc[num_rows]       = pc;
			row_hist[num_rows]     = hist;
			row_predict[num_rows]  = rp;
			row_taken[num_rows]    = taken;
			row_local[num_rows]    = tl;
			row_global[num_rows]   = tg;
			row_exp_plg[num_rows]  = exp_plg;
			row_exp_hist[num_rows] = exp_hist;
		end
		num_rows++;
	endtask

	task automatic load_table();
		// expected {predict, local, global} and history hold before the row's edge
		//      op                 pc    hist   rp tk lp gp  exp     hist
		// after reset everything reads not-taken
		add_row(OP_IDLE,           PC_A, 8'h00, 0, 0, 0, 0, 3'b000, 8'h00);
		add_row(OP_IDLE, 32'h1234_5678, 8'h00, 0, 0, 0, 0, 3'b000, 8'h00);
		// local training at A
		// reads in the write cycle see the old counter
		add_row(OP_TRAIN,          PC_A, 8'h00, 0, 1, 0, 0, 3'b000, 8'h00);
		add_row(OP_IDLE,           PC_A, 8'h00, 0, 0, 0, 0, 3'b111, 8'h00);
		add_row(OP_IDLE,           PC_B, 8'h00, 0, 0, 0, 0, 3'b000, 8'h00);
		add_row(OP_TRAIN,          PC_A, 8'h00, 0, 1, 0, 0, 3'b111, 8'h00);
		add_row(OP_TRAIN,          PC_A, 8'h00, 0, 1, 0, 0, 3'b111, 8'h00);
		add_row(OP_TRAIN,          PC_A, 8'h00, 0, 0, 1, 1, 3'b111, 8'h00);
		add_row(OP_IDLE,           PC_A, 8'h00, 0, 0, 0, 0, 3'b111, 8'h00);
		// speculative shifts then lookups without the strobe
		add_row(OP_LOOKUP,         PC_A, 8'h00, 0, 0, 0, 0, 3'b111, 8'h00);
		add_row(OP_LOOKUP,         PC_A, 8'h00, 0, 0, 0, 0, 3'b110, 8'h01);
		add_row(OP_LOOKUP,         PC_B, 8'h00, 0, 0, 0, 0, 3'b000, 8'h03);
		add_row(OP_IDLE,           PC_A, 8'h00, 0, 0, 0, 0, 3'b110, 8'h06);
		add_row(OP_IDLE,           PC_B, 8'h00, 0, 0, 0, 0, 3'b000, 8'h06);
		// chooser at C learns that global is right
		add_row(OP_TRAIN,          PC_C, 8'h10, 0, 0, 1, 0, 3'b000, 8'h06);
		add_row(OP_TRAIN,          PC_C, 8'h10, 0, 0, 1, 0, 3'b000, 8'h06);
		add_row(OP_TRAIN,          PC_C, 8'h06, 0, 1, 0, 0, 3'b000, 8'h06);
		add_row(OP_IDLE,           PC_C, 8'h00, 0, 0, 0, 0, 3'b101, 8'h06);
		// repair on mispredict but not on a correct resolve
		add_row(OP_RESOLVE,        PC_B, 8'h5a, 1, 0, 0, 0, 3'b000, 8'h06);
		add_row(OP_RESOLVE,        PC_B, 8'h33, 1, 1, 0, 0, 3'b000, 8'hb4);
		add_row(OP_RESOLVE_LOOKUP, PC_A, 8'h0f, 0, 1, 0, 0, 3'b110, 8'hb4);
		add_row(OP_IDLE,           PC_B, 8'h00, 0, 0, 0, 0, 3'b000, 8'h1f);
		// global entry at D only hits with the trained history
		add_row(OP_TRAIN,          PC_D, 8'h1f, 0, 1, 0, 0, 3'b000, 8'h1f);
		add_row(OP_IDLE,           PC_D, 8'h00, 0, 0, 0, 0, 3'b111, 8'h1f);
		add_row(OP_LOOKUP,         PC_D, 8'h00, 0, 0, 0, 0, 3'b111, 8'h1f);
		add_row(OP_IDLE,           PC_D, 8'h00, 0, 0, 0, 0, 3'b110, 8'h3f);
		add_row(OP_RESOLVE,        PC_D, 8'h0f, 0, 1, 0, 0, 3'b110, 8'h3f);
		add_row(OP_IDLE,           PC_D, 8'h00, 0, 0, 0, 0, 3'b111, 8'h1f);
		add_row(OP_IDLE,           PC_A, 8'h00, 0, 0, 0, 0, 3'b110, 8'h1f);
	endtask

	task automatic apply_row(input int r);
		lookup_valid_i         = (row_op[r] == OP_LOOKUP) || (row_op[r] == OP_RESOLVE_LOOKUP);
		resolve_valid_i        = (row_op[r] == OP_RESOLVE) || (row_op[r] == OP_RESOLVE_LOOKUP);
		train_valid_i          = (row_op[r] == OP_TRAIN);
		lookup_pc_i            = row_pc[r];
		train_pc_i             = row_pc[r];
		resolve_history_i      = row_hist[r];
		train_history_i        = row_hist[r];
		resolve_predict_i      = row_predict[r];
		resolve_taken_i        = row_taken[r];
		train_taken_i          = row_taken[r];
		train_local_predict_i  = row_local[r];
		train_global_predict_i = row_global[r];
	endtask

	task automatic check_row(input int r);
		cur_row = r;
		check_bit("predict_taken_o", predict_taken_o, row_exp_plg[r][2]);
		check_bit("local_predict_o", local_predict_o, row_exp_plg[r][1]);
		check_bit("global_predict_o", global_predict_o, row_exp_plg[r][0]);
		check_hist("lookup_history_o", lookup_history_o, row_exp_hist[r]);
	endtask

	// ********************************************************************
	// run limit
	// ********************************************************************

	always @(posedge clk_i) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout");
		end
	end

	// ********************************************************************
	// main sequence
	// ********************************************************************

	initial begin
		rst_i                  = 1'b1;
		lookup_valid_i         = 1'b0;
		lookup_pc_i            = '0;
		resolve_valid_i        = 1'b0;
		resolve_history_i      = '0;
		resolve_predict_i      = 1'b0;
		resolve_taken_i        = 1'b0;
		train_valid_i          = 1'b0;
		train_pc_i             = '0;
		train_history_i        = '0;
		train_taken_i          = 1'b0;
		train_local_predict_i  = 1'b0;
		train_global_predict_i = 1'b0;

		load_table();
		if (num_rows != NUM_ROWS) begin
			$display("stimulus table holds %0d rows instead of %0d", num_rows, NUM_ROWS);
			$display("TESTBENCH FAILED");
			$fatal(1, "bad table size");
		end

		repeat (RESET_CYCLES) @(negedge clk_i);
		rst_i = 1'b0;

		// lookup outputs are sampled 1 ns after the inputs change
		for (int r = 0; r < NUM_ROWS; r++) begin
			@(negedge clk_i);
			apply_row(r);
			#1;
			check_row(r);
		end

		@(negedge clk_i);
		lookup_valid_i  = 1'b0;
		resolve_valid_i = 1'b0;
		train_valid_i   = 1'b0;

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
cbp_pkg.sv
sat_counter_table.sv
global_history.sv
predict_select.sv
predictor_update.sv
branch_predictor.sv
tb_clock_gen.sv
tb_branch_predictor.sv
